//--- hdl/dadda_params.svh
`ifndef DADDA_PARAMS_SVH
`define DADDA_PARAMS_SVH

// operand width of a and b
`define DADDA_WIDTH 16

// product width, also the number of columns in the tree
`define DADDA_PROD_WIDTH 32

// bits per lookahead group in the final adder
`define DADDA_CLA_GROUP 4

// edges from input strobe to output strobe
`define DADDA_LATENCY 3

`endif

//--- hdl/dadda_pkg.sv
`default_nettype none

`include "dadda_params.svh"

package dadda_pkg;

    typedef logic [`DADDA_WIDTH-1:0] operand_t;
    typedef logic [`DADDA_PROD_WIDTH-1:0] product_t;

    // one entry per column, bit 0 of a column is its bottom bit
    typedef logic [`DADDA_PROD_WIDTH-1:0][`DADDA_WIDTH-1:0] col_matrix_t;
    typedef product_t [1:0] row_pair_t;

    function automatic int dadda_pp_height(int col);
        if (col < `DADDA_WIDTH) begin
            return col + 1;
        end
        if (col >= 2 * `DADDA_WIDTH - 1) begin
            return 0;
        end
        return 2 * `DADDA_WIDTH - 1 - col;
    endfunction

    // largest Dadda number below limit
    function automatic int dadda_next_target(int limit);
        int d;
        d = 2;
        while ((d * 3) / 2 < limit) begin
            d = (d * 3) / 2;
        end
        return d;
    endfunction

    // replays every stage from the partial products down to target
    function automatic int dadda_out_height(int col, int target);
        int h [`DADDA_PROD_WIDTH];
        int limit;
        int carry;
        int excess;
        for (int i = 0; i < `DADDA_PROD_WIDTH; i++) begin
            h[i] = dadda_pp_height(i);
        end
        limit = `DADDA_WIDTH;
        while (limit > target && limit > 2) begin
            limit = dadda_next_target(limit);
            carry = 0;
            for (int i = 0; i < `DADDA_PROD_WIDTH; i++) begin
                excess = h[i] + carry - limit;
                if (excess > 0) begin
                    h[i] = limit;
                    carry = (excess + 1) / 2;
                end else begin
                    h[i] = h[i] + carry;
                    carry = 0;
                end
            end
        end
        return h[col];
    endfunction

endpackage

`default_nettype wire

//--- hdl/dadda_reduce_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "dadda_params.svh"

module dadda_reduce_stage #(
    parameter int TARGET_HEIGHT = 2,
    parameter int IN_LIMIT      = 3
) (
    input  dadda_pkg::col_matrix_t cols_in,
    output dadda_pkg::col_matrix_t cols_out
);
    import dadda_pkg::*;

    localparam int PW = `DADDA_PROD_WIDTH;
    localparam int W  = `DADDA_WIDTH;

    // number of counters in the column below, hence carries arriving here
    function automatic int carries_into(int col);
        int carry;
        int excess;
        carry = 0;
        for (int i = 0; i < col; i++) begin
            excess = dadda_out_height(i, IN_LIMIT) + carry - TARGET_HEIGHT;
            carry = (excess > 0) ? (excess + 1) / 2 : 0;
        end
        return carry;
    endfunction

    // carries of column j, consumed by column j+1
    wire [PW-1:0][W-1:0] carry_rows;

    for (genvar j = 0; j < PW; j++) begin : g_col
        localparam int H_IN   = dadda_out_height(j, IN_LIMIT);
        localparam int C_IN   = carries_into(j);
        localparam int EXCESS = H_IN + C_IN - TARGET_HEIGHT;
        localparam int N_FA   = (EXCESS > 0) ? EXCESS / 2 : 0;
        localparam int N_HA   = (EXCESS > 0) ? EXCESS % 2 : 0;
        localparam int N_SUM  = N_FA + N_HA;
        localparam int N_USED = 3 * N_FA + 2 * N_HA;
        localparam int N_PASS = H_IN - N_USED;
        localparam int H_OUT  = dadda_out_height(j, TARGET_HEIGHT);

        wire [W-1:0] sum_bits;

        // full adders take the bottom bits, the half adder the next two
        for (genvar k = 0; k < W; k++) begin : g_cnt
            if (k < N_FA) begin : g_fa
                assign sum_bits[k] = cols_in[j][3*k] ^ cols_in[j][3*k+1] ^ cols_in[j][3*k+2];
                assign carry_rows[j][k] = (cols_in[j][3*k] & cols_in[j][3*k+1])
                                        | (cols_in[j][3*k+1] & cols_in[j][3*k+2])
                                        | (cols_in[j][3*k+2] & cols_in[j][3*k]);
            end else if (k < N_SUM) begin : g_ha
                assign sum_bits[k] = cols_in[j][N_USED-2] ^ cols_in[j][N_USED-1];
                assign carry_rows[j][k] = cols_in[j][N_USED-2] & cols_in[j][N_USED-1];
            end else begin : g_none
                assign sum_bits[k] = 1'b0;
                assign carry_rows[j][k] = 1'b0;
            end
        end

        // sums, then untouched bits, then carries from below
        for (genvar p = 0; p < W; p++) begin : g_out
            if (p < N_SUM) begin : g_sum
                assign cols_out[j][p] = sum_bits[p];
            end else if (p < N_SUM + N_PASS) begin : g_pass
                assign cols_out[j][p] = cols_in[j][N_USED + p - N_SUM];
            end else if (p < H_OUT) begin : g_carry
                assign cols_out[j][p] = carry_rows[j-1][p - N_SUM - N_PASS];
            end else begin : g_zero
                assign cols_out[j][p] = 1'b0;
            end
        end

        // the stage before must respect its own height
        a_in_height: assert final (|(cols_in[j] >> H_IN) !== 1'b1)
            else $error("column %0d has a bit above height %0d", j, H_IN);
    end

endmodule

`default_nettype wire

//--- hdl/dadda_tree_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "dadda_params.svh"

module dadda_tree_front (
    input  logic                   clk,
    input  logic                   front_load,
    input  dadda_pkg::operand_t    a,
    input  dadda_pkg::operand_t    b,
    output dadda_pkg::col_matrix_t front_cols
);
    import dadda_pkg::*;

    col_matrix_t pp_cols;
    col_matrix_t cols_13;
    col_matrix_t cols_9;
    col_matrix_t cols_6;

    // and array, each bit stacked in the column of weight i+j
    always_comb begin
        pp_cols = '0;
        for (int i = 0; i < `DADDA_WIDTH; i++) begin
            for (int j = 0; j < `DADDA_WIDTH; j++) begin
                pp_cols[i+j][(i + j < `DADDA_WIDTH) ? i : `DADDA_WIDTH - 1 - j] = a[i] & b[j];
            end
        end
    end

    dadda_reduce_stage #(
        .TARGET_HEIGHT(13),
        .IN_LIMIT     (`DADDA_WIDTH)
    ) u_stage_13 (
        .cols_in (pp_cols),
        .cols_out(cols_13)
    );

    dadda_reduce_stage #(
        .TARGET_HEIGHT(9),
        .IN_LIMIT     (13)
    ) u_stage_9 (
        .cols_in (cols_13),
        .cols_out(cols_9)
    );

    dadda_reduce_stage #(
        .TARGET_HEIGHT(6),
        .IN_LIMIT     (9)
    ) u_stage_6 (
        .cols_in (cols_9),
        .cols_out(cols_6)
    );

    always_ff @(posedge clk) begin
        if (front_load) begin
            front_cols <= cols_6;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dadda_tree_back.sv
`timescale 1ns/1ps
`default_nettype none

`include "dadda_params.svh"

module dadda_tree_back (
    input  logic                   clk,
    input  logic                   back_load,
    input  dadda_pkg::col_matrix_t front_cols,
    output dadda_pkg::row_pair_t   tree_rows
);
    import dadda_pkg::*;

    col_matrix_t cols_4;
    col_matrix_t cols_3;
    col_matrix_t cols_2;
    row_pair_t   rows_next;

    dadda_reduce_stage #(
        .TARGET_HEIGHT(4),
        .IN_LIMIT     (6)
    ) u_stage_4 (
        .cols_in (front_cols),
        .cols_out(cols_4)
    );

    dadda_reduce_stage #(
        .TARGET_HEIGHT(3),
        .IN_LIMIT     (4)
    ) u_stage_3 (
        .cols_in (cols_4),
        .cols_out(cols_3)
    );

    dadda_reduce_stage #(
        .TARGET_HEIGHT(2),
        .IN_LIMIT     (3)
    ) u_stage_2 (
        .cols_in (cols_3),
        .cols_out(cols_2)
    );

    // two bits per column left, one per row
    always_comb begin
        for (int c = 0; c < `DADDA_PROD_WIDTH; c++) begin
            rows_next[0][c] = cols_2[c][0];
            rows_next[1][c] = cols_2[c][1];
        end
    end

    always_ff @(posedge clk) begin
        if (back_load) begin
            tree_rows <= rows_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cla_adder.sv
`timescale 1ns/1ps
`default_nettype none

`include "dadda_params.svh"

module cla_adder (
    input  logic                 clk,
    input  logic                 sum_load,
    input  dadda_pkg::row_pair_t tree_rows,
    output dadda_pkg::product_t  product
);
    import dadda_pkg::*;

    localparam int PW  = `DADDA_PROD_WIDTH;
    localparam int GRP = `DADDA_CLA_GROUP;
    localparam int NG  = PW / GRP;

    product_t        gen;
    product_t        prop;
    product_t        carry;
    product_t        sum;
    logic [NG-1:0]   grp_gen;
    logic [NG-1:0]   grp_prop;
    logic [NG:0]     grp_carry;

    assign gen  = tree_rows[0] & tree_rows[1];
    assign prop = tree_rows[0] ^ tree_rows[1];

    // group generate and propagate
    always_comb begin
        logic term;
        for (int m = 0; m < NG; m++) begin
            grp_prop[m] = &prop[m*GRP +: GRP];
            grp_gen[m] = 1'b0;
            for (int u = 0; u < GRP; u++) begin
                term = gen[m*GRP + u];
                for (int v = u + 1; v < GRP; v++) begin
                    term = term & prop[m*GRP + v];
                end
                grp_gen[m] = grp_gen[m] | term;
            end
        end
    end

    // second level lookahead, no carry into bit 0
    always_comb begin
        logic term;
        grp_carry[0] = 1'b0;
        for (int m = 1; m <= NG; m++) begin
            grp_carry[m] = 1'b0;
            for (int l = 0; l < m; l++) begin
                term = grp_gen[l];
                for (int n = l + 1; n < m; n++) begin
                    term = term & grp_prop[n];
                end
                grp_carry[m] = grp_carry[m] | term;
            end
        end
    end

    // carries inside a group from its group carry
    always_comb begin
        logic term;
        int   base;
        for (int m = 0; m < NG; m++) begin
            base = m * GRP;
            for (int t = 0; t < GRP; t++) begin
                carry[base + t] = grp_carry[m];
                for (int v = 0; v < t; v++) begin
                    carry[base + t] = carry[base + t] & prop[base + v];
                end
                for (int u = 0; u < t; u++) begin
                    term = gen[base + u];
                    for (int v = u + 1; v < t; v++) begin
                        term = term & prop[base + v];
                    end
                    carry[base + t] = carry[base + t] | term;
                end
            end
        end
    end

    assign sum = prop ^ carry;

    always_ff @(posedge clk) begin
        if (sum_load) begin
            product <= sum;
        end
    end

    // the two tree rows of any operand pair must sum below 2**32
    a_no_carry_out: assert property (@(posedge clk) sum_load |-> !grp_carry[NG])
        else $error("carry out of the product msb");

endmodule

`default_nettype wire

//--- hdl/mul_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dadda_params.svh"

module mul_pipe_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic front_load,
    output logic back_load,
    output logic sum_load,
    output logic out_valid
);

    // operands are captured in the same edge as the strobe
    assign front_load = in_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            back_load <= 1'b0;
            sum_load  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            back_load <= front_load;
            sum_load  <= back_load;
            out_valid <= sum_load;
        end
    end

    // every strobe comes out after the full pipeline, unless reset cuts in
    a_latency: assert property (
        @(posedge clk) disable iff (reset)
        in_valid |-> ##(`DADDA_LATENCY) out_valid
    ) else $error("out_valid missing after in_valid");

    a_no_spurious: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> $past(in_valid, `DADDA_LATENCY)
    ) else $error("out_valid without a matching in_valid");

    a_reset_clear: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high right after reset");

endmodule

`default_nettype wire

//--- hdl/dadda_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dadda_params.svh"

module dadda_mul_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  dadda_pkg::operand_t a,
    input  dadda_pkg::operand_t b,
    output logic                out_valid,
    output dadda_pkg::product_t product
);
    import dadda_pkg::*;

    logic        front_load;
    logic        back_load;
    logic        sum_load;
    col_matrix_t front_cols;
    row_pair_t   tree_rows;

    mul_pipe_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .front_load(front_load),
        .back_load (back_load),
        .sum_load  (sum_load),
        .out_valid (out_valid)
    );

    dadda_tree_front u_front (
        .clk       (clk),
        .front_load(front_load),
        .a         (a),
        .b         (b),
        .front_cols(front_cols)
    );

    dadda_tree_back u_back (
        .clk       (clk),
        .back_load (back_load),
        .front_cols(front_cols),
        .tree_rows (tree_rows)
    );

    cla_adder u_adder (
        .clk      (clk),
        .sum_load (sum_load),
        .tree_rows(tree_rows),
        .product  (product)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD       = 20.0,
    parameter int  RESET_CYCLES = 4
) (
    input  logic reset_req,
    output logic clk,
    output logic reset
);

    logic init_reset;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // power-on reset, released just after an edge
    initial begin
        init_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        init_reset = 1'b0;
    end

    assign reset = init_reset | reset_req;

endmodule

`default_nettype wire

//--- verification/tb_dadda_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "dadda_params.svh"

module tb_dadda_mul;
    import dadda_pkg::*;

    // about 725 strobes, 300 gap cycles, reset and drains
    localparam int  CYCLE_LIMIT = 2000;
    localparam time DRIVE_DELAY = 2ns;
    localparam int  LAT         = `DADDA_LATENCY;

    logic     clk;
    logic     reset;
    logic     reset_req;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t product;

    product_t        exp_q[$];
    logic [15:0]     lfsr_state = 16'd3;
    logic [LAT-1:0]  vhist = '0;
    int pass_count  = 0;
    int fail_count  = 0;
    int total_in    = 0;
    int total_out   = 0;
    int cancelled   = 0;
    int run_len     = 0;
    int max_run     = 0;
    int cycle_count = 0;
    operand_t corner_a[5] = '{16'h0000, 16'h0000, 16'h0001, 16'hffff, 16'h8000};
    operand_t corner_b[5] = '{16'h0000, 16'hffff, 16'hffff, 16'hffff, 16'h8000};

    tb_clock_gen u_clk_gen (
        .reset_req(reset_req),
        .clk      (clk),
        .reset    (reset)
    );

    dadda_mul_top dut (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .out_valid(out_valid),
        .product  (product)
    );

    // full-width unsigned product of the zero-extended operands
    function automatic product_t expected_product(input operand_t x, input operand_t y);
        product_t wide_x;
        product_t wide_y;
        wide_x = product_t'(x);
        wide_y = product_t'(y);
        return wide_x * wide_y;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic strobe(input operand_t x, input operand_t y);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b1;
        a = x;
        b = y;
        exp_q.push_back(expected_product(x, y));
        total_in++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int strobes, input int fails_before);
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < 4 * LAT) begin
            idle(1);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("test %s ended with %0d products never delivered", name, exp_q.size());
            fail_count++;
        end
        idle(2);
        $display("test %-14s done: %0d strobes, %0d errors", name, strobes,
                 fail_count - fails_before);
    endtask

    // scoreboard, sampled mid-cycle where outputs are stable
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            total_out++;
            run_len++;
            if (run_len > max_run) begin
                max_run = run_len;
            end
            if (exp_q.size() == 0) begin
                $display("out_valid at %0t came with no product expected", $time);
                fail_count++;
            end else begin
                check_value("product", product, exp_q.pop_front());
            end
        end else begin
            run_len = 0;
        end
        check_value("out_valid", out_valid, vhist[LAT-1]);
        if (reset) begin
            cancelled += exp_q.size();
            exp_q.delete();
            vhist = '0;
        end else begin
            vhist = {vhist[LAT-2:0], in_valid};
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles with the tests unfinished", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int          fails_before;
        int          outs_before;
        int          cancel_before;
        logic [15:0] ra;
        logic [15:0] rb;
        logic [15:0] gap;
        reset_req = 1'b0;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        while (reset !== 1'b0) @(posedge clk);

        fails_before = fail_count;
        for (int i = 0; i < 5; i++) begin
            strobe(corner_a[i], corner_b[i]);
            idle(LAT + 2);
        end
        finish_test("corners", 5, fails_before);

        // every partial product bit lit on its own
        fails_before = fail_count;
        for (int i = 0; i < `DADDA_WIDTH; i++) begin
            for (int j = 0; j < `DADDA_WIDTH; j++) begin
                strobe(operand_t'(1) << i, operand_t'(1) << j);
            end
        end
        finish_test("walking_ones", 256, fails_before);

        fails_before = fail_count;
        max_run = 0;
        for (int n = 0; n < 256; n++) begin
            take_bits(16, ra);
            take_bits(16, rb);
            strobe(ra, rb);
        end
        finish_test("back_to_back", 256, fails_before);
        check_value("out_valid run length", max_run, 256);

        fails_before = fail_count;
        for (int n = 0; n < 200; n++) begin
            take_bits(16, ra);
            take_bits(16, rb);
            strobe(ra, rb);
            take_bits(2, gap);
            idle(gap);
        end
        finish_test("random_gaps", 200, fails_before);

        // two products in flight when reset hits
        fails_before = fail_count;
        cancel_before = cancelled;
        strobe(16'h1234, 16'h5678);
        strobe(16'hffff, 16'h0002);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
        reset_req = 1'b1;
        idle(2);
        reset_req = 1'b0;
        outs_before = total_out;
        idle(8);
        check_value("out_valid count after reset", total_out - outs_before, 0);
        check_value("cancelled strobes", cancelled - cancel_before, 2);
        for (int n = 0; n < 3; n++) begin
            take_bits(16, ra);
            take_bits(16, rb);
            strobe(ra, rb);
        end
        finish_test("reset_flight", 5, fails_before);

        check_value("output strobe count", total_out, total_in - cancelled);
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/dadda_pkg.sv
hdl/dadda_reduce_stage.sv
hdl/dadda_tree_front.sv
hdl/dadda_tree_back.sv
hdl/cla_adder.sv
hdl/mul_pipe_ctrl.sv
hdl/dadda_mul_top.sv
verification/tb_clock_gen.sv
verification/tb_dadda_mul.sv

//--- Bender.yml
package:
  name: dadda_mul

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dadda_pkg.sv
      - hdl/dadda_reduce_stage.sv
      - hdl/dadda_tree_front.sv
      - hdl/dadda_tree_back.sv
      - hdl/cla_adder.sv
      - hdl/mul_pipe_ctrl.sv
      - hdl/dadda_mul_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_dadda_mul.sv
